//--- tb.f
+incdir+tb
src/wide_add_pkg.sv
src/add_lo_stage.sv
src/add_hi_stage.sv
src/math_add_96.sv
src/wb_adder_regs.sv
src/wide_add_top.sv
tb/tb_wide_add.sv

//--- run.sh
#!/bin/sh
# build and run the 96-bit adder testbench with Verilator
# the run fails if the log holds the testbench's failure line

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_wide_add \
  && ./obj_dir/Vtb_wide_add > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "Some tests failed" sim.log \
  && { echo "simulation reported errors"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

//--- tb/tb_wide_add_tasks.svh
/*
  Bus tasks, reference model and directed tests for tb_wide_add.
  Included inside the testbench module and uses its signals directly.
*/

`ifndef TB_WIDE_ADD_TASKS_SVH
`define TB_WIDE_ADD_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// checking and reference model
//////////////////////////////////////////////////////////////////////

task automatic check_value(input string name, input logic [96:0] expected,
                           input logic [96:0] actual);
  checks++;
  assert (actual === expected) else begin
    $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    errors++;
  end
endtask

// carry on top; for subtract it is the no-borrow flag
function automatic logic [96:0] model_result(input logic [95:0] a, input logic [95:0] b,
                                             input logic op_sub);
  logic [96:0] r;
  if (op_sub) begin
    r[95:0] = a - b;
    r[96]   = (a >= b);
  end else begin
    r = {1'b0, a} + {1'b0, b};
  end
  return r;
endfunction

//////////////////////////////////////////////////////////////////////
// wishbone transfers
//////////////////////////////////////////////////////////////////////

task automatic wait_ack(input string what);
  int waited;
  waited = 0;
  @(negedge clk);
  while (!ack && waited < 16) begin
    @(negedge clk);
    waited++;
  end
  if (!ack) begin
    $display("timeout: no ack for %s", what);
    errors++;
  end
endtask

// drop the strobe and make sure ack does not repeat
task automatic end_transfer(input string what);
  cyc = 1'b0;
  stb = 1'b0;
  we  = 1'b0;
  xfer_count++;
  @(negedge clk);
  assert (!ack) else begin
    $display("second ack seen after %s", what);
    errors++;
  end
endtask

task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
  cyc   = 1'b1;
  stb   = 1'b1;
  we    = 1'b1;
  adr   = addr;
  dat_w = data;
  wait_ack($sformatf("write to address %0d", addr));
  end_transfer($sformatf("write to address %0d", addr));
endtask

task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
  cyc = 1'b1;
  stb = 1'b1;
  we  = 1'b0;
  adr = addr;
  wait_ack($sformatf("read of address %0d", addr));
  data = dat_r;
  end_transfer($sformatf("read of address %0d", addr));
endtask

//////////////////////////////////////////////////////////////////////
// operation helpers
//////////////////////////////////////////////////////////////////////

task automatic wait_done();
  logic [31:0] stat;
  int polls;
  polls = 0;
  stat  = 32'd0;
  while (!stat[1] && polls < 40) begin
    wb_read(wide_add_pkg::reg_stat, stat);
    polls++;
  end
  if (!stat[1]) begin
    $display("timeout: done flag never set in the status register");
    errors++;
  end
endtask

task automatic read_result(output logic [96:0] result);
  logic [31:0] r0;
  logic [31:0] r1;
  logic [31:0] r2;
  logic [31:0] r3;
  wb_read(wide_add_pkg::reg_r0, r0);
  wb_read(wide_add_pkg::reg_r1, r1);
  wb_read(wide_add_pkg::reg_r2, r2);
  wb_read(wide_add_pkg::reg_r3, r3);
  result = {r3[0], r2, r1, r0};
endtask

task automatic write_operands(input logic [95:0] a, input logic [95:0] b);
  wb_write(wide_add_pkg::reg_a0, a[31:0]);
  wb_write(wide_add_pkg::reg_a1, a[63:32]);
  wb_write(wide_add_pkg::reg_a2, a[95:64]);
  wb_write(wide_add_pkg::reg_b0, b[31:0]);
  wb_write(wide_add_pkg::reg_b1, b[63:32]);
  wb_write(wide_add_pkg::reg_b2, b[95:64]);
endtask

task automatic run_op(input logic [95:0] a, input logic [95:0] b, input logic op_sub,
                      output logic [96:0] result);
  write_operands(a, b);
  // start in bit 0, subtract in bit 1
  wb_write(wide_add_pkg::reg_ctrl, {30'd0, op_sub, 1'b1});
  wait_done();
  read_result(result);
endtask

task automatic check_op(input string name, input logic [95:0] a, input logic [95:0] b,
                        input logic op_sub);
  logic [96:0] got;
  run_op(a, b, op_sub, got);
  check_value(name, model_result(a, b, op_sub), got);
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_values();
  logic [31:0] got;
  int i;
  wb_read(wide_add_pkg::reg_stat, got);
  check_value("reset status", 97'd0, {65'd0, got});
  for (i = 0; i < 4; i++) begin
    wb_read(4'(8 + i), got);
    check_value($sformatf("reset r%0d", i), 97'd0, {65'd0, got});
  end
endtask

task automatic test_fixed_adds();
  logic [96:0] got;
  check_op("add zero plus zero", 96'd0, 96'd0, 1'b0);
  run_op({96{1'b1}}, 96'd1, 1'b0, got);
  check_value("add all ones plus one", {1'b1, 96'd0}, got);
  // low half full, so the carry has to cross into bit 48
  run_op({48'd0, {48{1'b1}}}, 96'd1, 1'b0, got);
  check_value("add ripple into bit 48", {1'b0, 47'd0, 1'b1, 48'd0}, got);
  check_op("add mixed halves", 96'h8000_0000_FFFF_1234_5678_9ABC,
           96'h7FFF_FFFF_0001_EDCB_A987_6544, 1'b0);
endtask

task automatic test_fixed_subs();
  logic [96:0] got;
  check_op("sub a above b", 96'd1000, 96'd1, 1'b1);
  check_op("sub a below b", 96'd5, 96'd9, 1'b1);
  check_op("sub borrow across halves", {32'h8000_0000, 64'd0}, 96'd1, 1'b1);
  run_op(96'h1357_9BDF_2468_ACE0_FEDC_BA98, 96'h1357_9BDF_2468_ACE0_FEDC_BA98, 1'b1, got);
  check_value("sub a minus a", {1'b1, 96'd0}, got);
endtask

task automatic test_random_ops();
  logic [95:0] a;
  logic [95:0] b;
  int i;
  for (i = 0; i < 24; i++) begin
    a = {$urandom(), $urandom(), $urandom()};
    b = {$urandom(), $urandom(), $urandom()};
    check_op($sformatf("random %0d", i), a, b, i[0]);
  end
endtask

task automatic test_busy_start();
  logic [95:0] a1;
  logic [95:0] b1;
  logic [96:0] got;
  logic [31:0] stat;
  logic prev_done;
  int rises;
  int k;
  a1 = 96'h0000_1111_2222_3333_4444_5555;
  b1 = 96'h0000_0000_0000_0000_0000_0007;
  write_operands(a1, b1);
  wb_write(wide_add_pkg::reg_ctrl, 32'h1);
  // new b and a subtract start while the add is still in flight
  wb_write(wide_add_pkg::reg_b0, 32'hFFFF_0000);
  wb_write(wide_add_pkg::reg_ctrl, 32'h3);
  wait_done();
  rises     = 1;
  prev_done = 1'b1;
  for (k = 0; k < 10; k++) begin
    wb_read(wide_add_pkg::reg_stat, stat);
    if (stat[1] && !prev_done) begin
      rises++;
    end
    prev_done = stat[1];
  end
  check_value("busy start done rises", 97'd1, {65'd0, rises});
  check_value("busy start final status", 97'd2, {65'd0, stat});
  read_result(got);
  check_value("busy start result", model_result(a1, b1, 1'b0), got);
endtask

task automatic test_register_access();
  logic [31:0] patterns [6];
  logic [31:0] got;
  int start_acks;
  int start_xfers;
  int i;
  start_acks  = ack_count;
  start_xfers = xfer_count;
  for (i = 0; i < 6; i++) begin
    patterns[i] = $urandom();
    wb_write(4'(i), patterns[i]);
  end
  for (i = 0; i < 6; i++) begin
    wb_read(4'(i), got);
    check_value($sformatf("readback address %0d", i), {65'd0, patterns[i]}, {65'd0, got});
  end
  wb_read(4'd15, got);
  check_value("unmapped address 15", 97'd0, {65'd0, got});
  check_value("one ack per transfer", {65'd0, xfer_count - start_xfers},
              {65'd0, ack_count - start_acks});
endtask

`endif

//--- tb/tb_wide_add.sv
/*
  Testbench for the 96-bit add/subtract unit behind its Wishbone slave.
  Inputs change on the falling edge, outputs are sampled there too.
  Random operands come from a fixed seed, so every run is the same.
*/

`timescale 1ns/10ps

module tb_wide_add;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  int errors;
  int checks;
  int ack_count;
  int xfer_count;

  wide_add_top uut (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #5 clk = ~clk;

  // ack is stable at the falling edge
  always @(negedge clk) begin
    if (ack) begin
      ack_count++;
    end
  end

  `include "tb_wide_add_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 4'd0;
    dat_w      = 32'd0;
    errors     = 0;
    checks     = 0;
    ack_count  = 0;
    xfer_count = 0;
    void'($urandom(32'h9876_7dc6));

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_values();
    test_fixed_adds();
    test_fixed_subs();
    test_random_ops();
    test_busy_start();
    test_register_access();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/wide_add_top.sv
/*
  96-bit add/subtract accelerator with a 32-bit Wishbone classic slave.
  No interrupt; software polls the done bit in the status register.
*/

`timescale 1ns/10ps

module wide_add_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            we,
  input  logic [3:0]                      adr,
  input  logic [wide_add_pkg::bus_w-1:0]  dat_w,
  output logic [wide_add_pkg::bus_w-1:0]  dat_r,
  output logic                            ack
);

  wide_add_pkg::add_req_t req;
  wide_add_pkg::add_res_t res;

  // bus front end
  wb_adder_regs u_regs (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .req   (req),
    .res   (res)
  );

  // three-cycle adder pipeline
  math_add_96 u_add (
    .clk (clk),
    .rst (rst),
    .req (req),
    .res (res)
  );

endmodule

//--- src/wb_adder_regs.sv
/*
  Wishbone classic slave for the adder, single transfers and full words only.
  Ack follows a request by one cycle; read data is registered with it.
  A start written while busy is dropped without notice.
*/

`timescale 1ns/10ps

module wb_adder_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            we,
  input  logic [3:0]                      adr,
  input  logic [wide_add_pkg::bus_w-1:0]  dat_w,
  output logic [wide_add_pkg::bus_w-1:0]  dat_r,
  output logic                            ack,
  output wide_add_pkg::add_req_t          req,
  input  wide_add_pkg::add_res_t          res
);

  logic                              req_hit;
  logic                              wr_en;
  logic                              start_wr;
  wide_add_pkg::wide_word_u          a_q;
  wide_add_pkg::wide_word_u          b_q;
  logic                              op_sub_q;
  logic                              req_valid_q;
  logic                              busy_q;
  logic                              done_q;
  logic [wide_add_pkg::word_w-1:0]   sum_q;
  logic                              carry_q;
  logic [wide_add_pkg::bus_w-1:0]    rd_data;

  //////////////////////////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////////////////////////

  // new request, not yet acked
  assign req_hit  = cyc & stb & ~ack;
  assign wr_en    = req_hit & we;
  assign start_wr = wr_en && (adr == wide_add_pkg::reg_ctrl)
                  && dat_w[wide_add_pkg::ctrl_start_bit] && !busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req_hit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operand registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q.word <= '0;
      b_q.word <= '0;
    end else if (wr_en) begin
      case (adr)
        wide_add_pkg::reg_a0: a_q.word[31:0]  <= dat_w;
        wide_add_pkg::reg_a1: a_q.word[63:32] <= dat_w;
        wide_add_pkg::reg_a2: a_q.word[95:64] <= dat_w;
        wide_add_pkg::reg_b0: b_q.word[31:0]  <= dat_w;
        wide_add_pkg::reg_b1: b_q.word[63:32] <= dat_w;
        wide_add_pkg::reg_b2: b_q.word[95:64] <= dat_w;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control, status and result
  //////////////////////////////////////////////////////////////////////

  // busy blocks a second start until the result is back
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      op_sub_q    <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      req_valid_q <= start_wr;
      if (start_wr) begin
        op_sub_q <= dat_w[wide_add_pkg::ctrl_sub_bit];
        busy_q   <= 1'b1;
        done_q   <= 1'b0;
      end else if (res.valid) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q   <= '0;
      carry_q <= 1'b0;
    end else if (res.valid) begin
      sum_q   <= res.sum;
      carry_q <= res.carry_out;
    end
  end

  // operands go straight from the registers, the pulse marks the item
  always_comb begin
    req.valid  = req_valid_q;
    req.op_sub = op_sub_q;
    req.a      = a_q;
    req.b      = b_q;
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (adr)
      wide_add_pkg::reg_a0:   rd_data = a_q.word[31:0];
      wide_add_pkg::reg_a1:   rd_data = a_q.word[63:32];
      wide_add_pkg::reg_a2:   rd_data = a_q.word[95:64];
      wide_add_pkg::reg_b0:   rd_data = b_q.word[31:0];
      wide_add_pkg::reg_b1:   rd_data = b_q.word[63:32];
      wide_add_pkg::reg_b2:   rd_data = b_q.word[95:64];
      // start is a strobe, only the op bit reads back
      wide_add_pkg::reg_ctrl: rd_data[wide_add_pkg::ctrl_sub_bit] = op_sub_q;
      wide_add_pkg::reg_stat: begin
        rd_data[wide_add_pkg::stat_busy_bit] = busy_q;
        rd_data[wide_add_pkg::stat_done_bit] = done_q;
      end
      wide_add_pkg::reg_r0:   rd_data = sum_q[31:0];
      wide_add_pkg::reg_r1:   rd_data = sum_q[63:32];
      wide_add_pkg::reg_r2:   rd_data = sum_q[95:64];
      wide_add_pkg::reg_r3:   rd_data[0] = carry_q;
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dat_r <= '0;
    end else if (req_hit && !we) begin
      dat_r <= rd_data;
    end
  end

endmodule

//--- src/math_add_96.sv
/*
  96-bit add/subtract pipeline, three cycles from req to res.
  Accepts one item per clock with no back-pressure.
  Subtract carry_out is the no-borrow flag (one when a >= b).
*/

`timescale 1ns/10ps

module math_add_96 (
  input  logic                   clk,
  input  logic                   rst,
  input  wide_add_pkg::add_req_t req,
  output wide_add_pkg::add_res_t res
);

  wide_add_pkg::add_req_t  req_d;
  wide_add_pkg::add_req_t  req_q;
  wide_add_pkg::lo_stage_t lo_q;

  //////////////////////////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////////////////////////

  // a - b becomes a + ~b + 1, the +1 comes in as the low carry
  always_comb begin
    req_d = req;
    if (req.op_sub) begin
      req_d.b.word = ~req.b.word;
    end
  end

  always_ff @(posedge clk) begin
    req_q <= req_d;
    if (rst) begin
      req_q.valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // adder halves
  //////////////////////////////////////////////////////////////////////

  add_lo_stage u_lo (
    .clk (clk),
    .rst (rst),
    .in  (req_q),
    .out (lo_q)
  );

  add_hi_stage u_hi (
    .clk (clk),
    .rst (rst),
    .in  (lo_q),
    .out (res)
  );

endmodule

//--- src/add_hi_stage.sv
/*
  High 48-bit adder stage, one cycle of latency.
  Takes the carry stored by the low stage and returns the 97-bit result.
*/

`timescale 1ns/10ps

module add_hi_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  wide_add_pkg::lo_stage_t in,
  output wide_add_pkg::add_res_t  out
);

  logic [wide_add_pkg::half_w:0] hi_sum;
  wide_add_pkg::add_res_t         res_d;
  wide_add_pkg::add_res_t         res_q;

  assign hi_sum = {1'b0, in.a_hi} + {1'b0, in.b_hi}
                + {{wide_add_pkg::half_w{1'b0}}, in.carry};

  always_comb begin
    res_d.valid     = in.valid;
    // upper half on top of the stored low sum
    res_d.sum       = {hi_sum[wide_add_pkg::half_w-1:0], in.sum_lo};
    res_d.carry_out = hi_sum[wide_add_pkg::half_w];
  end

  always_ff @(posedge clk) begin
    res_q <= res_d;
    if (rst) begin
      res_q.valid <= 1'b0;
    end
  end

  assign out = res_q;

endmodule

//--- src/add_lo_stage.sv
/*
  Low 48-bit adder stage, one cycle of latency.
  Operand b must already be inverted for subtract; op_sub only supplies
  the carry-in here.
*/

`timescale 1ns/10ps

module add_lo_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  wide_add_pkg::add_req_t  in,
  output wide_add_pkg::lo_stage_t out
);

  logic [wide_add_pkg::half_w:0] lo_sum;
  wide_add_pkg::lo_stage_t        stage_d;
  wide_add_pkg::lo_stage_t        stage_q;

  // extra top bit catches the carry into bit 48
  assign lo_sum = {1'b0, in.a.halves.lo} + {1'b0, in.b.halves.lo}
                + {{wide_add_pkg::half_w{1'b0}}, in.op_sub};

  always_comb begin
    stage_d.valid  = in.valid;
    stage_d.sum_lo = lo_sum[wide_add_pkg::half_w-1:0];
    stage_d.carry  = lo_sum[wide_add_pkg::half_w];
    // high halves wait one cycle to line up with the carry
    stage_d.a_hi   = in.a.halves.hi;
    stage_d.b_hi   = in.b.halves.hi;
  end

  // only the valid bit is cleared
  always_ff @(posedge clk) begin
    stage_q <= stage_d;
    if (rst) begin
      stage_q.valid <= 1'b0;
    end
  end

  assign out = stage_q;

endmodule

//--- src/wide_add_pkg.sv
/*
  Shared widths, register map and pipeline types for the 96-bit adder.
  Widths follow from the split into two 48-bit halves and are not meant
  to be changed on their own.
*/

package wide_add_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int half_w = 48;
  localparam int word_w = 96;
  localparam int bus_w  = 32;

  //////////////////////////////////////////////////////////////////////
  // register word addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [3:0] reg_a0   = 4'd0;
  localparam logic [3:0] reg_a1   = 4'd1;
  localparam logic [3:0] reg_a2   = 4'd2;
  localparam logic [3:0] reg_b0   = 4'd3;
  localparam logic [3:0] reg_b1   = 4'd4;
  localparam logic [3:0] reg_b2   = 4'd5;
  localparam logic [3:0] reg_ctrl = 4'd6;
  localparam logic [3:0] reg_stat = 4'd7;
  localparam logic [3:0] reg_r0   = 4'd8;
  localparam logic [3:0] reg_r1   = 4'd9;
  localparam logic [3:0] reg_r2   = 4'd10;
  localparam logic [3:0] reg_r3   = 4'd11;

  // bit positions in ctrl and stat
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_sub_bit   = 1;
  localparam int stat_busy_bit  = 0;
  localparam int stat_done_bit  = 1;

  //////////////////////////////////////////////////////////////////////
  // operand and pipeline types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [half_w-1:0] hi;
    logic [half_w-1:0] lo;
  } wide_halves_t;

  // flat view for the bus side, split view for the adder stages
  typedef union packed {
    logic [word_w-1:0] word;
    wide_halves_t      halves;
  } wide_word_u;

  typedef struct packed {
    logic       valid;
    logic       op_sub;
    wide_word_u a;
    wide_word_u b;
  } add_req_t;

  // low half done, high halves carried along
  typedef struct packed {
    logic              valid;
    logic [half_w-1:0] sum_lo;
    logic              carry;
    logic [half_w-1:0] a_hi;
    logic [half_w-1:0] b_hi;
  } lo_stage_t;

  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] sum;
    logic              carry_out;
  } add_res_t;

endpackage
